/* tests/move_order_input.txt */
// side (1 white, 0 black) count entries[count] sorted_ids[count] max_eval min_eval check_count
// entry = {id[5:0], white_in_check, black_in_check, eval[11:0]}, all values hex
1 0 800 7ff 0
0 1 51123 14 123 123 1
1 2 00010 10020 04 00 020 010 0
1 3 00005 11005 22005 04 00 08 005 005 2
0 3 00005 11005 22005 08 00 04 005 005 2
1 4 30064 70f9c 13000 903e8 24 0c 04 1c 3e8 f9c 1
0 4 30064 70f9c 13000 903e8 1c 04 0c 24 3e8 f9c 1
1 5 007ff 10800 217ff 30001 42800 08 00 0c 04 10 7ff 800 2
0 5 007ff 10800 217ff 30001 42800 10 04 0c 00 08 7ff 800 2
1 6 00003 1100a 20ffb 30007 42000 5000c 14 04 0c 00 10 08 00c ffb 2
0 7 00050 10fce 20019 33f00 40100 50000 60fff 0c 04 18 14 08 00 10 100 f00 1
1 8 00080 10070 20060 30050 40040 50030 60020 70010 00 04 08 0c 10 14 18 1c 080 010 0
0 9 01009 10008 20007 30006 40005 50004 60003 70002 82001 20 1c 18 14 10 0c 08 04 00 009 001 2
1 a 00000 11000 22000 33000 40000 51000 60000 72000 81000 90000 04 0c 14 20 00 08 10 18 1c 24 000 000 6
0 b 000f0 10f10 20005 30ff0 400a0 50800 627ff 70033 80fc0 90001 a1100 14 04 20 0c 24 08 1c 10 00 28 18 7ff 800 2
1 c 00005 1000b 20ffe 33000 40009 51fff 60003 7000a 82fe0 90007 a0001 b000c 2c 04 1c 10 24 00 18 28 0c 14 08 20 00c fe0 3
0 d 00010 10020 20030 30040 40050 50060 60070 70080 80090 900a0 a00b0 b00c0 c2005 30 00 04 08 0c 10 14 18 1c 20 24 28 2c 0c0 005 1
1 e 00001 10002 20003 30004 40005 50006 60007 70008 80009 9000a a000b b000c c000d d000e 34 30 2c 28 24 20 1c 18 14 10 0c 08 04 00 00e 001 0
0 f 00007 10006 20005 30004 40003 50002 60001 73000 80fff 90ffe a0ffd b0ffc c0ffb d0ffa e1ff9 38 34 30 2c 28 24 20 1c 18 14 10 0c 08 04 00 007 ff9 2
1 10 00000 11000 21001 30001 42002 50002 60003 73003 80004 90004 a0005 b0005 c0006 d0006 e0007 f0007 38 3c 30 34 28 2c 20 24 1c 18 10 14 08 0c 04 00 007 000 4

/* build.f */
hdl/move_order_pkg.sv
hdl/move_ram.sv
hdl/move_sort.sv
hdl/move_stats.sv
hdl/move_order_apb.sv
hdl/move_order_top.sv
tests/move_order_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   -f build.f --top-module move_order_tb -o move_order_sim || exit 1
sim_out="$(./obj_dir/move_order_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Testbench passed" && exit 0 || exit 1

/* tests/move_order_tb.sv */
`timescale 1ns/1ps

module move_order_tb;

   localparam int STIM_DEPTH = 1024;
   localparam int MAX_CASES = 20;
   // Loads, worst-case sort and readback of every case with a margin of two
   localparam int CYCLE_LIMIT = MAX_CASES * (16 + 16 * 16 * 4 + 16 * 4) * 2;

   logic clk;
   logic reset;
   logic psel;
   logic penable;
   logic pwrite;
   logic [7:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;

   logic [31:0] stim [0:STIM_DEPTH-1];
   int ptr = 0;
   int case_num = 0;
   int error_count = 0;
   int check_total = 0;
   int cycle_count = 0;

   move_order_top i_move_order_top
   (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles in case %0d, the DUT never finished", cycle_count,
                  case_num);
         $display("Testbench failed");
         $finish;
      end
   end

   function automatic logic [31:0] sign_extend(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      check_total++;
      assert (got === exp)
      else
      begin
         error_count++;
         $display("error at %0t: case %0d %s read %h, expected %h", $time, case_num, what, got,
                  exp);
      end
   endtask

   // One APB3 transfer that returns after the completing edge
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      int waits;
      logic [31:0] exp_waits;
      waits = 0;
      exp_waits = (!wr && (addr == move_order_pkg::RD_DATA_ADDR)) ? 32'd1 : 32'd0;
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= wr;
      paddr <= addr;
      pwdata <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      while (!pready)
      begin
         waits++;
         @(posedge clk);
      end
      rdata = prdata;
      err = pslverr;
      psel <= 1'b0;
      penable <= 1'b0;
      check_value(waits, exp_waits, "pready wait states");
   endtask

   task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                               input logic exp_err, input string what);
      logic [31:0] rdata;
      logic err;
      apb_xfer(1'b1, addr, data, rdata, err);
      check_value({31'b0, err}, {31'b0, exp_err}, what);
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
      logic [31:0] rdata;
      logic err;
      apb_xfer(1'b0, addr, 32'h0, rdata, err);
      check_value(rdata, exp, what);
   endtask

   task automatic check_stats(input int base, input string when);
      read_expect(move_order_pkg::MAX_EVAL_ADDR, sign_extend(stim[base][11:0]),
                  {"MAX_EVAL ", when});
      read_expect(move_order_pkg::MIN_EVAL_ADDR, sign_extend(stim[base + 1][11:0]),
                  {"MIN_EVAL ", when});
      read_expect(move_order_pkg::CHECK_CNT_ADDR, stim[base + 2], {"CHECK_CNT ", when});
   endtask

   task automatic run_case();
      logic [31:0] rdata;
      logic err;
      logic [31:0] side_bits;
      int n;
      int id_base;
      int stat_base;
      side_bits = {29'b0, stim[ptr][0], 2'b00};   // CTRL bit 2
      n = stim[ptr + 1];
      id_base = ptr + 2 + n;
      stat_base = id_base + n;
      write_expect(move_order_pkg::CTRL_ADDR, side_bits | 32'h8, 1'b0, "rewind");
      read_expect(move_order_pkg::STATUS_ADDR, 32'h0, "STATUS after rewind");
      for (int i = 0; i < n; i++)
      begin
         write_expect(move_order_pkg::DATA_ADDR, stim[ptr + 2 + i], 1'b0, "DATA pslverr");
      end
      read_expect(move_order_pkg::STATUS_ADDR, n << 8, "STATUS after load");
      check_stats(stat_base, "before sort");
      write_expect(move_order_pkg::CTRL_ADDR, side_bits | 32'h1, 1'b0, "start");
      if (n >= 2)
      begin
         // Would raise the max and the check count if it got through
         write_expect(move_order_pkg::DATA_ADDR, 32'hff7ff, 1'b1, "DATA pslverr while busy");
      end
      rdata = '0;
      while (!rdata[0])
      begin
         apb_xfer(1'b0, move_order_pkg::STATUS_ADDR, 32'h0, rdata, err);
      end
      read_expect(move_order_pkg::STATUS_ADDR, (n << 8) | 1, "STATUS when complete");
      for (int i = 0; i < n; i++)
      begin
         write_expect(move_order_pkg::RD_ADDR_ADDR, i, 1'b0, "RD_ADDR pslverr");
         apb_xfer(1'b0, move_order_pkg::RD_DATA_ADDR, 32'h0, rdata, err);
         check_value({26'b0, rdata[19:14]}, stim[id_base + i], $sformatf("id at %0d", i));
      end
      check_stats(stat_base, "after sort");
      write_expect(move_order_pkg::CTRL_ADDR, side_bits | 32'h2, 1'b0, "clear");
      read_expect(move_order_pkg::STATUS_ADDR, n << 8, "STATUS after clear");
      ptr = stat_base + 3;
      case_num++;
   endtask

   initial
   begin
      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = 8'h0;
      pwdata = 32'h0;
      for (int i = 0; i < STIM_DEPTH; i++)
      begin
         stim[i] = '1;   // End marker past the last case
      end
      $readmemh("tests/move_order_input.txt", stim);
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      while ((stim[ptr] != '1) && (case_num < MAX_CASES))
      begin
         run_case();
      end
      $display("Cases: %0d, checks: %0d, errors: %0d", case_num, check_total, error_count);
      if (error_count == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* hdl/move_order_top.sv */
`timescale 1ns/1ps

module move_order_top
(
   input  logic        clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   logic sort_start;
   logic sort_clear;
   logic white_to_move;
   logic load_init;
   logic load_wr;
   logic sort_busy;
   logic sort_complete;
   move_order_pkg::entry_t load_data;
   move_order_pkg::entry_t rd_data;
   move_order_pkg::move_addr_t rd_addr;
   move_order_pkg::count_t load_count;
   move_order_pkg::count_t check_count;
   move_order_pkg::eval_t max_eval;
   move_order_pkg::eval_t min_eval;

   move_order_apb i_move_order_apb
   (
      .clk           (clk),
      .reset         (reset),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .load_init     (load_init),
      .load_wr       (load_wr),
      .load_data     (load_data),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .load_count    (load_count),
      .sort_busy     (sort_busy),
      .sort_complete (sort_complete),
      .max_eval      (max_eval),
      .min_eval      (min_eval),
      .check_count   (check_count)
   );

   move_sort i_move_sort
   (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .load_init     (load_init),
      .load_wr       (load_wr),
      .load_data     (load_data),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .load_count    (load_count),
      .sort_busy     (sort_busy),
      .sort_complete (sort_complete)
   );

   // Sees the same load stream as the sorter
   move_stats i_move_stats
   (
      .clk         (clk),
      .reset       (reset),
      .load_init   (load_init),
      .load_wr     (load_wr),
      .load_data   (load_data),
      .max_eval    (max_eval),
      .min_eval    (min_eval),
      .check_count (check_count)
   );

endmodule

/* hdl/move_order_apb.sv */
`timescale 1ns/1ps

module move_order_apb
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [7:0]                 paddr,
   input  logic [31:0]                pwdata,
   output logic [31:0]                prdata,
   output logic                       pready,
   output logic                       pslverr,
   output logic                       sort_start,
   output logic                       sort_clear,
   output logic                       white_to_move,
   output logic                       load_init,
   output logic                       load_wr,
   output move_order_pkg::entry_t     load_data,
   output move_order_pkg::move_addr_t rd_addr,
   input  move_order_pkg::entry_t     rd_data,
   input  move_order_pkg::count_t     load_count,
   input  logic                       sort_busy,
   input  logic                       sort_complete,
   input  move_order_pkg::eval_t      max_eval,
   input  move_order_pkg::eval_t      min_eval,
   input  move_order_pkg::count_t     check_count
);

   logic rd_wait;
   logic rd_data_access;
   logic wr_xfer;
   logic data_wr;

   assign rd_data_access = psel && penable && !pwrite && (paddr == move_order_pkg::RD_DATA_ADDR);
   assign pready = !(rd_data_access && !rd_wait);   // One wait state for the RAM read
   assign wr_xfer = psel && penable && pwrite && pready;
   assign data_wr = wr_xfer && (paddr == move_order_pkg::DATA_ADDR);
   assign pslverr = data_wr && sort_busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_wait <= 1'b0;
         sort_start <= 1'b0;
         sort_clear <= 1'b0;
         load_init <= 1'b0;
         load_wr <= 1'b0;
         white_to_move <= 1'b0;
         rd_addr <= '0;
      end
      else
      begin
         rd_wait <= rd_data_access && !rd_wait;
         sort_start <= 1'b0;
         sort_clear <= 1'b0;
         load_init <= 1'b0;
         load_wr <= data_wr && !sort_busy && (load_count < move_order_pkg::MAX_MOVES);
         if (wr_xfer && (paddr == move_order_pkg::CTRL_ADDR))
         begin
            sort_start <= pwdata[0];
            sort_clear <= pwdata[1];
            white_to_move <= pwdata[2];
            load_init <= pwdata[3];
         end
         if (wr_xfer && (paddr == move_order_pkg::RD_ADDR_ADDR))
         begin
            rd_addr <= pwdata[move_order_pkg::MAX_MOVES_LOG2-1:0];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (data_wr)
      begin
         load_data <= pwdata[move_order_pkg::ENTRY_WIDTH-1:0];
      end
   end

   always_comb
   begin
      prdata = '0;
      case (paddr)
         move_order_pkg::CTRL_ADDR: prdata[2] = white_to_move;
         move_order_pkg::STATUS_ADDR:
         begin
            prdata[0] = sort_complete;
            prdata[1] = sort_busy;
            prdata[8 +: move_order_pkg::MAX_MOVES_LOG2 + 1] = load_count;
         end
         move_order_pkg::RD_ADDR_ADDR: prdata[move_order_pkg::MAX_MOVES_LOG2-1:0] = rd_addr;
         move_order_pkg::RD_DATA_ADDR: prdata[move_order_pkg::ENTRY_WIDTH-1:0] = rd_data;
         move_order_pkg::MAX_EVAL_ADDR:
         begin
            prdata = {{(32 - move_order_pkg::EVAL_WIDTH){max_eval[move_order_pkg::EVAL_WIDTH-1]}},
                      max_eval};
         end
         move_order_pkg::MIN_EVAL_ADDR:
         begin
            prdata = {{(32 - move_order_pkg::EVAL_WIDTH){min_eval[move_order_pkg::EVAL_WIDTH-1]}},
                      min_eval};
         end
         move_order_pkg::CHECK_CNT_ADDR: prdata[move_order_pkg::MAX_MOVES_LOG2:0] = check_count;
         default: prdata = '0;
      endcase
   end

   // Refused write makes no load pulse
   a_slverr_no_load: assert property (@(posedge clk) disable iff (reset)
      pslverr |=> !load_wr);

endmodule

/* hdl/move_stats.sv */
`timescale 1ns/1ps

module move_stats
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   load_init,
   input  logic                   load_wr,
   input  move_order_pkg::entry_t load_data,
   output move_order_pkg::eval_t  max_eval,
   output move_order_pkg::eval_t  min_eval,
   output move_order_pkg::count_t check_count
);

   move_order_pkg::eval_t new_eval;
   logic gives_check;

   assign new_eval = move_order_pkg::eval_t'(load_data[move_order_pkg::EVAL_WIDTH-1:0]);
   assign gives_check = load_data[move_order_pkg::WHITE_CHECK_BIT] |
                        load_data[move_order_pkg::BLACK_CHECK_BIT];

   always_ff @(posedge clk)
   begin
      if (reset || load_init)
      begin
         max_eval <= move_order_pkg::EVAL_MOST_NEG;
         min_eval <= move_order_pkg::EVAL_MOST_POS;
         check_count <= '0;
      end
      else if (load_wr)
      begin
         if (new_eval > max_eval)   // Signed compare
         begin
            max_eval <= new_eval;
         end
         if (new_eval < min_eval)
         begin
            min_eval <= new_eval;
         end
         if (gives_check)
         begin
            check_count <= check_count + 1'b1;
         end
      end
   end

   // Loads stop at capacity in the register block
   a_check_count_cap: assert property (@(posedge clk) disable iff (reset)
      check_count <= move_order_pkg::MAX_MOVES);

endmodule

/* hdl/move_sort.sv */
`timescale 1ns/1ps

module move_sort
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       sort_start,
   input  logic                       sort_clear,
   input  logic                       white_to_move,
   input  logic                       load_init,
   input  logic                       load_wr,
   input  move_order_pkg::entry_t     load_data,
   input  move_order_pkg::move_addr_t rd_addr,
   output move_order_pkg::entry_t     rd_data,
   output move_order_pkg::count_t     load_count,
   output logic                       sort_busy,
   output logic                       sort_complete
);

   move_order_pkg::sort_state_t state;

   move_order_pkg::count_t n;          // Current pass length
   move_order_pkg::count_t last_swap;
   move_order_pkg::move_addr_t ptr_a;
   move_order_pkg::move_addr_t ptr_b;
   move_order_pkg::move_addr_t sort_addr_a;
   move_order_pkg::move_addr_t sort_addr_b;

   logic ext_io;
   logic sort_wr;
   logic swap_needed;
   logic last_pair;

   logic a_wr_en;
   logic b_wr_en;
   move_order_pkg::move_addr_t a_addr;
   move_order_pkg::move_addr_t b_addr;
   move_order_pkg::entry_t a_wr_data;
   move_order_pkg::entry_t a_rd_data;
   move_order_pkg::entry_t b_rd_data;
   move_order_pkg::eval_t eval_a;
   move_order_pkg::eval_t eval_b;

   // RAM belongs to the host while idle or done
   assign ext_io = (state == move_order_pkg::idle) || (state == move_order_pkg::done);
   assign sort_busy = !ext_io;
   assign sort_wr = (state == move_order_pkg::swap);

   assign a_addr = ext_io ? load_count[move_order_pkg::MAX_MOVES_LOG2-1:0] : sort_addr_a;
   assign b_addr = ext_io ? rd_addr : sort_addr_b;
   assign a_wr_en = ext_io ? load_wr : sort_wr;
   assign b_wr_en = ext_io ? 1'b0 : sort_wr;
   assign a_wr_data = ext_io ? load_data : b_rd_data;   // Swap crosses the read data
   assign rd_data = b_rd_data;

   assign eval_a = move_order_pkg::eval_t'(a_rd_data[move_order_pkg::EVAL_WIDTH-1:0]);
   assign eval_b = move_order_pkg::eval_t'(b_rd_data[move_order_pkg::EVAL_WIDTH-1:0]);

   // Strict condition keeps load order on full ties
   always_comb
   begin
      if (white_to_move)
      begin
         swap_needed = (eval_a < eval_b) ||
            ((eval_a == eval_b) && !a_rd_data[move_order_pkg::BLACK_CHECK_BIT] &&
             b_rd_data[move_order_pkg::BLACK_CHECK_BIT]);
      end
      else
      begin
         swap_needed = (eval_a > eval_b) ||
            ((eval_a == eval_b) && !a_rd_data[move_order_pkg::WHITE_CHECK_BIT] &&
             b_rd_data[move_order_pkg::WHITE_CHECK_BIT]);
      end
   end

   assign last_pair = ({1'b0, ptr_b} == move_order_pkg::count_t'(n - 1'b1));

   // Address the next pair ahead so read data is ready in compare
   always_comb
   begin
      sort_addr_a = ptr_a;
      sort_addr_b = ptr_b;
      case (state)
         move_order_pkg::outer_init:
         begin
            sort_addr_a = '0;
            sort_addr_b = move_order_pkg::move_addr_t'(1);
         end
         move_order_pkg::inner:
         begin
            sort_addr_a = ptr_a + 1'b1;
            sort_addr_b = ptr_b + 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset || load_init)
      begin
         load_count <= '0;
      end
      else if (ext_io && load_wr)
      begin
         load_count <= load_count + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= move_order_pkg::idle;
         sort_complete <= 1'b0;
      end
      else
      begin
         case (state)
            move_order_pkg::idle:
            begin
               if (sort_start)
               begin
                  if (load_count < 2)
                  begin
                     state <= move_order_pkg::done;
                     sort_complete <= 1'b1;
                  end
                  else
                  begin
                     state <= move_order_pkg::outer_init;
                  end
               end
            end
            move_order_pkg::outer_init: state <= move_order_pkg::compare;
            move_order_pkg::compare:
            begin
               state <= swap_needed ? move_order_pkg::swap : move_order_pkg::inner;
            end
            move_order_pkg::swap: state <= move_order_pkg::inner;
            move_order_pkg::inner:
            begin
               state <= last_pair ? move_order_pkg::outer_check : move_order_pkg::compare;
            end
            move_order_pkg::outer_check:
            begin
               if (last_swap > 1)
               begin
                  state <= move_order_pkg::outer_init;
               end
               else
               begin
                  state <= move_order_pkg::done;
                  sort_complete <= 1'b1;
               end
            end
            move_order_pkg::done:
            begin
               if (sort_clear)
               begin
                  state <= move_order_pkg::idle;
                  sort_complete <= 1'b0;
               end
            end
            default: state <= move_order_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      case (state)
         move_order_pkg::idle: n <= load_count;
         move_order_pkg::outer_init:
         begin
            ptr_a <= '0;
            ptr_b <= move_order_pkg::move_addr_t'(1);
            last_swap <= '0;
         end
         move_order_pkg::swap: last_swap <= {1'b0, ptr_b};
         move_order_pkg::inner:
         begin
            ptr_a <= ptr_a + 1'b1;
            ptr_b <= ptr_b + 1'b1;
         end
         move_order_pkg::outer_check: n <= last_swap;   // Tail beyond last swap is sorted
         default:
         begin
         end
      endcase
   end

   move_ram i_move_ram
   (
      .clk       (clk),
      .a_wr_en   (a_wr_en),
      .a_addr    (a_addr),
      .a_wr_data (a_wr_data),
      .a_rd_data (a_rd_data),
      .b_wr_en   (b_wr_en),
      .b_addr    (b_addr),
      .b_wr_data (a_rd_data),
      .b_rd_data (b_rd_data)
   );

   // Sort writes only follow a compare that asked for a swap
   a_sort_write_after_compare: assert property (@(posedge clk) disable iff (reset)
      sort_wr |-> $past((state == move_order_pkg::compare) && swap_needed));

   a_complete_in_done: assert property (@(posedge clk) disable iff (reset)
      sort_complete |-> (state == move_order_pkg::done));

endmodule

/* hdl/move_ram.sv */
`timescale 1ns/1ps

module move_ram
(
   input  logic                     clk,
   input  logic                     a_wr_en,
   input  move_order_pkg::move_addr_t a_addr,
   input  move_order_pkg::entry_t   a_wr_data,
   output move_order_pkg::entry_t   a_rd_data,
   input  logic                     b_wr_en,
   input  move_order_pkg::move_addr_t b_addr,
   input  move_order_pkg::entry_t   b_wr_data,
   output move_order_pkg::entry_t   b_rd_data
);

   move_order_pkg::entry_t mem [0:move_order_pkg::MAX_MOVES-1];

   // Read-first on both ports
   always_ff @(posedge clk)
   begin
      a_rd_data <= mem[a_addr];
      b_rd_data <= mem[b_addr];
      if (a_wr_en)
      begin
         mem[a_addr] <= a_wr_data;
      end
      if (b_wr_en)
      begin
         mem[b_addr] <= b_wr_data;
      end
   end

endmodule

/* hdl/move_order_pkg.sv */
package move_order_pkg;

   // List capacity
   localparam int MAX_MOVES_LOG2 = 4;
   localparam int MAX_MOVES = 1 << MAX_MOVES_LOG2;

   // Entry layout with the evaluation in the low bits
   localparam int EVAL_WIDTH = 12;
   localparam int ENTRY_WIDTH = 20;
   localparam int BLACK_CHECK_BIT = 12;
   localparam int WHITE_CHECK_BIT = 13;

   typedef logic signed [EVAL_WIDTH-1:0] eval_t;
   typedef logic [ENTRY_WIDTH-1:0] entry_t;
   typedef logic [MAX_MOVES_LOG2-1:0] move_addr_t;
   typedef logic [MAX_MOVES_LOG2:0] count_t;

   // Reset values of the running extremes
   localparam eval_t EVAL_MOST_POS = {1'b0, {(EVAL_WIDTH-1){1'b1}}};
   localparam eval_t EVAL_MOST_NEG = {1'b1, {(EVAL_WIDTH-1){1'b0}}};

   typedef enum logic [2:0]
   {
      idle,
      outer_init,
      compare,
      swap,
      inner,
      outer_check,
      done
   } sort_state_t;

   // APB register offsets
   localparam logic [7:0] CTRL_ADDR = 8'h00;
   localparam logic [7:0] DATA_ADDR = 8'h04;
   localparam logic [7:0] STATUS_ADDR = 8'h08;
   localparam logic [7:0] RD_ADDR_ADDR = 8'h0C;
   localparam logic [7:0] RD_DATA_ADDR = 8'h10;
   localparam logic [7:0] MAX_EVAL_ADDR = 8'h14;
   localparam logic [7:0] MIN_EVAL_ADDR = 8'h18;
   localparam logic [7:0] CHECK_CNT_ADDR = 8'h1C;

endpackage
